// File: hw/aluPkg.sv
package aluPkg;

	////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////

	// default width, the top level overrides through WIDTH
	localparam int dataWidth = 16;

	////////////////////////////////////////////////////////////
	// major opcodes, instruction bits 15 to 12
	////////////////////////////////////////////////////////////

	// register form, func picks the operation
	localparam logic [3:0] opRType   = 4'b0000;
	localparam logic [3:0] opAndi    = 4'b0001;
	localparam logic [3:0] opOri     = 4'b0010;
	localparam logic [3:0] opXori    = 4'b0011;
	// scond and jcond live here
	localparam logic [3:0] opSpecial = 4'b0100;
	localparam logic [3:0] opAddi    = 4'b0101;
	localparam logic [3:0] opAddci   = 4'b0111;
	// lsh, lshi, ashui
	localparam logic [3:0] opShift   = 4'b1000;
	localparam logic [3:0] opSubi    = 4'b1001;
	localparam logic [3:0] opSubci   = 4'b1010;
	localparam logic [3:0] opCmpi    = 4'b1011;
	localparam logic [3:0] opBcond   = 4'b1100;
	localparam logic [3:0] opMovi    = 4'b1101;
	localparam logic [3:0] opMuli    = 4'b1110;
	localparam logic [3:0] opLui     = 4'b1111;

	// function extension under opRType
	localparam logic [3:0] fnAnd  = 4'b0001;
	localparam logic [3:0] fnOr   = 4'b0010;
	localparam logic [3:0] fnXor  = 4'b0011;
	localparam logic [3:0] fnAdd  = 4'b0101;
	localparam logic [3:0] fnAddc = 4'b0111;
	localparam logic [3:0] fnSub  = 4'b1001;
	localparam logic [3:0] fnSubc = 4'b1010;
	localparam logic [3:0] fnCmp  = 4'b1011;
	localparam logic [3:0] fnMov  = 4'b1101;
	localparam logic [3:0] fnMul  = 4'b1110;
	localparam logic [3:0] fnNot  = 4'b1111;

	// function extension under opShift
	localparam logic [3:0] fnLshi  = 4'b0000;
	localparam logic [3:0] fnAshui = 4'b0010;
	localparam logic [3:0] fnLsh   = 4'b0100;

	// function extension under opSpecial
	localparam logic [3:0] fnJcond = 4'b1100;
	localparam logic [3:0] fnScond = 4'b1101;

	////////////////////////////////////////////////////////////
	// internal alu control
	////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		ctrlAdd   = 5'b00000,
		ctrlSub   = 5'b00001,
		ctrlMul   = 5'b00010,
		ctrlAnd   = 5'b00011,
		ctrlOr    = 5'b00100,
		ctrlXor   = 5'b00101,
		ctrlScond = 5'b00111,
		ctrlMov   = 5'b01000,
		ctrlLui   = 5'b01001,
		ctrlNot   = 5'b01010,
		ctrlLsh   = 5'b01011,
		ctrlLshi  = 5'b01100,
		ctrlAshui = 5'b01111,
		ctrlBcond = 5'b10000,
		ctrlJcond = 5'b10001
	} aluCtrlT;

	// condition codes, 15 is unused and reads as false
	localparam logic [3:0] condEq = 4'd0;
	localparam logic [3:0] condNe = 4'd1;
	localparam logic [3:0] condCs = 4'd2;
	localparam logic [3:0] condCc = 4'd3;
	localparam logic [3:0] condHi = 4'd4;
	localparam logic [3:0] condLs = 4'd5;
	localparam logic [3:0] condGt = 4'd6;
	localparam logic [3:0] condLe = 4'd7;
	localparam logic [3:0] condFs = 4'd8;
	localparam logic [3:0] condFc = 4'd9;
	localparam logic [3:0] condLo = 4'd10;
	localparam logic [3:0] condHs = 4'd11;
	localparam logic [3:0] condLt = 4'd12;
	localparam logic [3:0] condGe = 4'd13;
	localparam logic [3:0] condUc = 4'd14;

	// psr bit positions, C L F Z N from msb down
	localparam int psrC = 4;
	localparam int psrL = 3;
	localparam int psrF = 2;
	localparam int psrZ = 1;
	localparam int psrN = 0;

endpackage

// File: hw/aluController.sv
`timescale 1ns/1ps
module aluController import aluPkg::*; (
	input  logic [3:0] oper,
	input  logic [3:0] func,
	output aluCtrlT    ctrl,
	output logic [4:0] psrWrEn,
	output logic       carryIn
);

	// flag masks per operation class
	localparam logic [4:0] maskArith = (5'b1 << psrC) | (5'b1 << psrF);
	localparam logic [4:0] maskCmp   = (5'b1 << psrL) | (5'b1 << psrZ) | (5'b1 << psrN);

	// immediate forms fold onto the register func code
	logic [3:0] baseFn;
	// high when oper is rtype or one of the plain immediate forms
	logic baseOk;

	always_comb begin
		baseOk = 1'b1;
		case (oper)
			opRType: baseFn = func;
			opAndi:  baseFn = fnAnd;
			opOri:   baseFn = fnOr;
			opXori:  baseFn = fnXor;
			opAddi:  baseFn = fnAdd;
			opAddci: baseFn = fnAddc;
			opSubi:  baseFn = fnSub;
			opSubci: baseFn = fnSubc;
			opCmpi:  baseFn = fnCmp;
			opMovi:  baseFn = fnMov;
			opMuli:  baseFn = fnMul;
			default: begin
				baseOk = 1'b0;
				baseFn = func;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// control code and flag mask
	////////////////////////////////////////////////////////////

	always_comb begin
		// unknown encodings fall through as a flagless move
		ctrl = ctrlMov;
		psrWrEn = '0;
		carryIn = 1'b0;
		if (baseOk) begin
			case (baseFn)
				fnAnd: ctrl = ctrlAnd;
				fnOr:  ctrl = ctrlOr;
				fnXor: ctrl = ctrlXor;
				fnMul: ctrl = ctrlMul;
				fnMov: ctrl = ctrlMov;
				// not has no immediate form, only reachable from rtype
				fnNot: ctrl = ctrlNot;
				fnAdd, fnAddc: begin
					ctrl = ctrlAdd;
					psrWrEn = maskArith;
					carryIn = (baseFn == fnAddc);
				end
				fnSub, fnSubc: begin
					ctrl = ctrlSub;
					psrWrEn = maskArith;
					carryIn = (baseFn == fnSubc);
				end
				// compare reuses the subtractor, only L Z N land
				fnCmp: begin
					ctrl = ctrlSub;
					psrWrEn = maskCmp;
				end
				default: ctrl = ctrlMov;
			endcase
		end else begin
			case (oper)
				opShift: begin
					case (func)
						fnLsh:   ctrl = ctrlLsh;
						fnLshi:  ctrl = ctrlLshi;
						fnAshui: ctrl = ctrlAshui;
						default: ctrl = ctrlMov;
					endcase
				end
				opSpecial: begin
					case (func)
						fnScond: ctrl = ctrlScond;
						fnJcond: ctrl = ctrlJcond;
						default: ctrl = ctrlMov;
					endcase
				end
				opBcond: ctrl = ctrlBcond;
				opLui:   ctrl = ctrlLui;
				default: ctrl = ctrlMov;
			endcase
		end
	end

endmodule

// File: hw/conditionCheck.sv
`timescale 1ns/1ps
module conditionCheck import aluPkg::*; (
	input  logic [3:0] cond,
	input  logic [4:0] psrRead,
	output logic       condition
);

	// individual status bits
	logic c;
	logic l;
	logic f;
	logic z;
	logic n;

	assign c = psrRead[psrC];
	assign l = psrRead[psrL];
	assign f = psrRead[psrF];
	assign z = psrRead[psrZ];
	assign n = psrRead[psrN];

	always_comb begin
		case (cond)
			condEq: condition = z;
			condNe: condition = !z;
			condCs: condition = c;
			condCc: condition = !c;
			condHi: condition = l;
			condLs: condition = !l;
			condGt: condition = n;
			condLe: condition = !n;
			condFs: condition = f;
			condFc: condition = !f;
			// lower, strictly below and not equal
			condLo: condition = !l & !z;
			condHs: condition = l | z;
			condLt: condition = !n & !z;
			condGe: condition = n | z;
			condUc: condition = 1'b1;
			// code 15 never holds
			default: condition = 1'b0;
		endcase
	end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps
module alu import aluPkg::*; #(
	parameter int WIDTH = dataWidth
) (
	input  logic [WIDTH-1:0] dst,
	input  logic [WIDTH-1:0] src,
	input  logic [3:0]       oper,
	input  logic [3:0]       func,
	input  logic [3:0]       cond,
	input  logic [4:0]       psrRead,
	output logic [4:0]       psrWrEn,
	output logic [4:0]       psrWrite,
	output logic [WIDTH-1:0] result
);

	aluCtrlT ctrl;
	logic carryIn;
	logic condition;

	// decoder and condition test run side by side
	aluController aluController0 (
		.oper(oper),
		.func(func),
		.ctrl(ctrl),
		.psrWrEn(psrWrEn),
		.carryIn(carryIn)
	);

	conditionCheck conditionCheck0 (
		.cond(cond),
		.psrRead(psrRead),
		.condition(condition)
	);

	////////////////////////////////////////////////////////////
	// shared adder for add, sub and cmp
	////////////////////////////////////////////////////////////

	logic isSub;
	logic cIn;
	logic addIn;
	logic [WIDTH-1:0] bOp;
	logic [WIDTH-1:0] sum;
	logic carryOut;

	assign isSub = (ctrl == ctrlSub);
	// psr carry only enters for addc and subc
	assign cIn = carryIn & psrRead[psrC];
	// subtract as dst + ~src + 1 - borrow
	assign bOp = isSub ? ~src : src;
	assign addIn = isSub ^ cIn;
	assign {carryOut, sum} = {1'b0, dst} + {1'b0, bOp} + {{WIDTH{1'b0}}, addIn};

	// flag candidates, psrWrEn picks which ones land
	logic flagC;
	logic flagF;
	logic flagL;
	logic flagN;
	logic flagZ;

	// carry out of the inverted add means no borrow
	assign flagC = isSub ? ~carryOut : carryOut;
	// operands agree in sign but the sum does not
	assign flagF = (dst[WIDTH-1] == bOp[WIDTH-1]) && (sum[WIDTH-1] != dst[WIDTH-1]);
	assign flagL = (dst > src);
	assign flagN = ($signed(dst) > $signed(src));
	assign flagZ = (dst == src);

	always_comb begin
		psrWrite = '0;
		psrWrite[psrC] = flagC;
		psrWrite[psrL] = flagL;
		psrWrite[psrF] = flagF;
		psrWrite[psrZ] = flagZ;
		psrWrite[psrN] = flagN;
	end

	////////////////////////////////////////////////////////////
	// shifter
	////////////////////////////////////////////////////////////

	// right shift distance is the negated low five bits of src
	logic [4:0] amt;
	logic srcNeg;

	assign amt = -src[4:0];
	assign srcNeg = src[WIDTH-1];

	// result select
	always_comb begin
		case (ctrl)
			ctrlAdd:   result = sum;
			ctrlSub:   result = sum;
			// low half of the product only
			ctrlMul:   result = dst * src;
			ctrlAnd:   result = dst & src;
			ctrlOr:    result = dst | src;
			ctrlXor:   result = dst ^ src;
			ctrlNot:   result = ~dst;
			ctrlMov:   result = src;
			ctrlLui:   result = WIDTH'({src[7:0], dst[7:0]});
			ctrlScond: result = {{(WIDTH-1){1'b0}}, condition};
			// lsh keeps four bits of distance either way
			ctrlLsh:   result = srcNeg ? (dst >> amt[3:0]) : (dst << src[3:0]);
			// lshi right can reach a full clear at -16
			ctrlLshi:  result = srcNeg ? (dst >> amt) : (dst << src[3:0]);
			ctrlAshui: result = $signed(dst) >>> amt;
			// branch target is pc relative, jump target absolute
			ctrlBcond: result = condition ? (dst + src) : dst;
			ctrlJcond: result = condition ? src : dst;
			default:   result = src;
		endcase
	end

endmodule

// File: hw/executeStage.sv
`timescale 1ns/1ps
module executeStage import aluPkg::*; #(
	parameter int WIDTH = dataWidth
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic             issue,
	input  logic [WIDTH-1:0] dst,
	input  logic [WIDTH-1:0] src,
	input  logic [3:0]       oper,
	input  logic [3:0]       func,
	input  logic [3:0]       cond,
	output logic [WIDTH-1:0] result,
	output logic             resultValid,
	output logic [4:0]       psr
);

	logic [WIDTH-1:0] aluResult;
	logic [4:0] psrWrEn;
	logic [4:0] psrWrite;

	// alu reads the registered psr, so back to back ops chain flags
	alu #(
		.WIDTH(WIDTH)
	) alu0 (
		.dst(dst),
		.src(src),
		.oper(oper),
		.func(func),
		.cond(cond),
		.psrRead(psr),
		.psrWrEn(psrWrEn),
		.psrWrite(psrWrite),
		.result(aluResult)
	);

	////////////////////////////////////////////////////////////
	// result, valid pulse and status register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			result <= '0;
			resultValid <= 1'b0;
			psr <= '0;
		end else begin
			// one cycle pulse per issue, no stall path
			resultValid <= issue;
			if (issue) begin
				result <= aluResult;
				// merge only the bits this op writes
				psr <= (psr & ~psrWrEn) | (psrWrite & psrWrEn);
			end
		end
	end

endmodule

// File: verification/executeStage_props.sv
`timescale 1ns/1ps
module executeStage_props (
	input logic       clk,
	input logic       rstN,
	input logic       issue,
	input logic       resultValid,
	input logic [4:0] psr
);

	// failed assertion count
	int failures = 0;

	// sync reset clears the pulse and the flags
	resetClears: assert property (@(posedge clk) !rstN |=> (!resultValid && psr == 5'b0))
		else begin
			$error("resultValid or psr not cleared by reset");
			failures++;
		end

	validFollowsIssue: assert property (@(posedge clk) disable iff (!rstN) issue |=> resultValid)
		else begin
			$error("resultValid missing one cycle after issue");
			failures++;
		end

	validOnlyAfterIssue: assert property (@(posedge clk) disable iff (!rstN)
		!issue |=> !resultValid)
		else begin
			$error("resultValid high without an issue the cycle before");
			failures++;
		end

	// flags only move on issue cycles
	psrHoldsWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
		!issue |=> $stable(psr))
		else begin
			$error("psr changed after a cycle without issue");
			failures++;
		end

endmodule

bind executeStage executeStage_props props0 (
	.clk(clk),
	.rstN(rstN),
	.issue(issue),
	.resultValid(resultValid),
	.psr(psr)
);

// File: verification/executeStage_tb.sv
`timescale 1ns/1ps
module executeStage_tb import aluPkg::*; ();

	localparam int width = 16;
	localparam int numArith = 40;
	localparam int numMix = 60;
	// edges, random arith, logic, compare groups, shifts, random mix
	localparam int plannedOps = 10 + numArith + 13 + 5 * 30 + 21 + numMix;
	localparam int timeoutNs = plannedOps * 8 * 4 + 400;

	logic clk = 1'b0;
	logic rstN;
	logic issue;
	logic [width-1:0] dst;
	logic [width-1:0] src;
	logic [3:0] oper;
	logic [3:0] func;
	logic [3:0] cond;
	logic [width-1:0] result;
	logic resultValid;
	logic [4:0] psr;

	integer seed = 48;
	int errors = 0;
	int checks = 0;
	int issued = 0;
	int k;
	logic issuedLast = 1'b0;
	logic [4:0] modelPsr = '0;
	// op, func, cond, expected psr, expected result
	logic [width+16:0] expQ[$];
	logic [width+16:0] head;
	logic [7:0] opTable[28];
	logic [width-1:0] cmpA[5] = '{16'h0005, 16'h0003, 16'h0009, 16'h8000, 16'h0001};
	logic [width-1:0] cmpB[5] = '{16'h0005, 16'h0009, 16'h0003, 16'h0001, 16'h8000};
	logic [width-1:0] shiftAmt[7] = '{16'd0, 16'd3, 16'd15, 16'hffff, 16'hfffc, 16'hfff1, 16'hfff0};

	executeStage #(
		.WIDTH(width)
	) dut0 (
		.clk(clk),
		.rstN(rstN),
		.issue(issue),
		.dst(dst),
		.src(src),
		.oper(oper),
		.func(func),
		.cond(cond),
		.result(result),
		.resultValid(resultValid),
		.psr(psr)
	);

	initial forever #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic logic condHolds(input logic [3:0] cd, input logic [4:0] p);
		case (cd)
			condEq: return p[psrZ];
			condNe: return !p[psrZ];
			condCs: return p[psrC];
			condCc: return !p[psrC];
			condHi: return p[psrL];
			condLs: return !p[psrL];
			condGt: return p[psrN];
			condLe: return !p[psrN];
			condFs: return p[psrF];
			condFc: return !p[psrF];
			condLo: return !p[psrL] && !p[psrZ];
			condHs: return p[psrL] || p[psrZ];
			condLt: return !p[psrN] && !p[psrZ];
			condGe: return p[psrN] || p[psrZ];
			condUc: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// returns {new psr, result}
	function automatic logic [width+4:0] expectedOutcome(input logic [3:0] op, fn, cd,
			input logic [width-1:0] d, s, input logic [4:0] p);
		logic [3:0] f;
		logic [width:0] wide;
		logic [width-1:0] r;
		logic [4:0] np;
		logic cin;
		logic [4:0] amt;
		logic signed [width-1:0] sd;
		np = p;
		// unknown encodings act as a flagless move
		r = s;
		amt = -s[4:0];
		sd = d;
		case (op)
			opRType: f = fn;
			opAndi:  f = fnAnd;
			opOri:   f = fnOr;
			opXori:  f = fnXor;
			opAddi:  f = fnAdd;
			opAddci: f = fnAddc;
			opSubi:  f = fnSub;
			opSubci: f = fnSubc;
			opCmpi:  f = fnCmp;
			opMovi:  f = fnMov;
			opMuli:  f = fnMul;
			default: f = 4'h0;
		endcase
		if (op == opShift) begin
			// negative amounts shift right
			if (fn == fnLsh)
				r = s[width-1] ? d >> amt[3:0] : d << s[3:0];
			else if (fn == fnLshi)
				r = s[width-1] ? d >> amt : d << s[3:0];
			else if (fn == fnAshui)
				r = sd >>> amt;
		end else if (op == opSpecial) begin
			if (fn == fnScond)
				r = {{(width-1){1'b0}}, condHolds(cd, p)};
			else if (fn == fnJcond)
				r = condHolds(cd, p) ? s : d;
		end else if (op == opBcond) begin
			r = condHolds(cd, p) ? d + s : d;
		end else if (op == opLui) begin
			r = width'({s[7:0], d[7:0]});
		end else begin
			case (f)
				fnAnd: r = d & s;
				fnOr:  r = d | s;
				fnXor: r = d ^ s;
				fnMul: r = d * s;
				fnNot: r = ~d;
				fnAdd, fnAddc: begin
					cin = (f == fnAddc) ? p[psrC] : 1'b0;
					wide = {1'b0, d} + {1'b0, s} + {{width{1'b0}}, cin};
					r = wide[width-1:0];
					np[psrC] = wide[width];
					np[psrF] = (d[width-1] == s[width-1]) && (r[width-1] != d[width-1]);
				end
				fnSub, fnSubc: begin
					// borrow in comes from psr C
					cin = (f == fnSubc) ? p[psrC] : 1'b0;
					r = d - s - width'(cin);
					np[psrC] = {1'b0, d} < ({1'b0, s} + {{width{1'b0}}, cin});
					np[psrF] = (d[width-1] != s[width-1]) && (r[width-1] != d[width-1]);
				end
				fnCmp: begin
					r = d - s;
					np[psrL] = d > s;
					np[psrN] = $signed(d) > $signed(s);
					np[psrZ] = d == s;
				end
				default: r = s;
			endcase
		end
		return {np, r};
	endfunction

	////////////////////////////////////////////////////////////
	// driving and checking
	////////////////////////////////////////////////////////////

	task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic issueOp(input logic [3:0] op, fn, cd, input logic [width-1:0] d, s);
		logic [width+4:0] outcome;
		@(negedge clk);
		oper = op;
		func = fn;
		cond = cd;
		dst = d;
		src = s;
		issue = 1'b1;
		outcome = expectedOutcome(op, fn, cd, d, s, modelPsr);
		// flags chain into the next op
		modelPsr = outcome[width+4:width];
		expQ.push_back({op, fn, cd, outcome});
		issued++;
	endtask

	task automatic idleCycle();
		@(negedge clk);
		issue = 1'b0;
		dst = width'($random(seed));
		src = width'($random(seed));
	endtask

	always @(posedge clk) issuedLast <= rstN & issue;

	// outputs settle at the rising edge, read them at the falling one
	always @(negedge clk) begin
		checkEq("resultValid", 32'(resultValid), 32'(issuedLast));
		if (resultValid === 1'b1) begin
			if (expQ.size() == 0) begin
				errors++;
				$display("Error at %0t ns: resultValid pulsed with no operation outstanding", $time);
			end else begin
				head = expQ.pop_front();
				checkEq($sformatf("result of op %h fn %h cond %h", head[width+13 +: 4],
					head[width+9 +: 4], head[width+5 +: 4]), 32'(result), 32'(head[width-1:0]));
				checkEq("psr", 32'(psr), 32'(head[width +: 5]));
			end
		end
	end

	initial begin
		#(timeoutNs);
		$display("Timeout: the run did not finish within %0d ns", timeoutNs);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		issue = 1'b0;
		dst = '0;
		src = '0;
		oper = '0;
		func = '0;
		cond = '0;
		opTable = '{{opRType, fnAdd}, {opRType, fnAddc}, {opRType, fnSub}, {opRType, fnSubc},
			{opAddi, 4'h0}, {opAddci, 4'h0}, {opSubi, 4'h0}, {opSubci, 4'h0},
			{opRType, fnCmp}, {opCmpi, 4'h0}, {opRType, fnAnd}, {opAndi, 4'h0},
			{opRType, fnOr}, {opOri, 4'h0}, {opRType, fnXor}, {opXori, 4'h0},
			{opRType, fnMov}, {opMovi, 4'h0}, {opRType, fnMul}, {opMuli, 4'h0},
			{opRType, fnNot}, {opLui, 4'h0}, {opShift, fnLsh}, {opShift, fnLshi},
			{opShift, fnAshui}, {opSpecial, fnScond}, {opSpecial, fnJcond}, {opBcond, 4'h0}};
		repeat (4) @(negedge clk);
		rstN = 1'b1;
		checkEq("result after reset", 32'(result), 32'h0);
		checkEq("psr after reset", 32'(psr), 32'h0);

		// carry and overflow edges, carry forms pick up the previous C
		issueOp(opRType, fnAdd, 4'h0, 16'h7fff, 16'h0001);
		issueOp(opRType, fnAdd, 4'h0, 16'hffff, 16'h0001);
		issueOp(opRType, fnAddc, 4'h0, 16'h0000, 16'h0000);
		issueOp(opAddi, 4'h0, 4'h0, 16'h8000, 16'h8000);
		issueOp(opAddci, 4'h0, 4'h0, 16'h1234, 16'h0001);
		issueOp(opRType, fnSub, 4'h0, 16'h0000, 16'h0001);
		issueOp(opRType, fnSubc, 4'h0, 16'h0005, 16'h0001);
		issueOp(opSubi, 4'h0, 4'h0, 16'h8000, 16'h0001);
		issueOp(opRType, fnSub, 4'h0, 16'h0000, 16'h0001);
		issueOp(opSubci, 4'h0, 4'h0, 16'h0000, 16'hffff);
		for (int i = 0; i < numArith; i++) begin
			k = $unsigned($random(seed)) % 8;
			issueOp(opTable[k][7:4], opTable[k][3:0], 4'h0, width'($random(seed)),
				width'($random(seed)));
		end

		// compare, then ops that must leave the psr alone
		issueOp(opRType, fnCmp, 4'h0, 16'h0005, 16'h0003);
		for (int j = 10; j < 22; j++) begin
			issueOp(opTable[j][7:4], opTable[j][3:0], 4'h0, width'($random(seed)),
				width'($random(seed)));
		end

		// every condition code after each compare, C and F from a random add
		for (int p = 0; p < 5; p++) begin
			issueOp(opRType, fnAdd, 4'h0, width'($random(seed)), width'($random(seed)));
			issueOp(opCmpi, 4'h0, 4'h0, cmpA[p], cmpB[p]);
			for (int c = 0; c < 16; c++) begin
				issueOp(opSpecial, fnScond, 4'(c), 16'h0000, 16'h0000);
			end
			for (int c = 0; c < 6; c++) begin
				issueOp(opBcond, 4'h0, 4'(c * 3), 16'h0100, 16'h0020);
				issueOp(opSpecial, fnJcond, 4'(c * 3), 16'h0100, 16'h0abc);
			end
		end

		// zero, positive and negative shift distances
		for (int a = 0; a < 7; a++) begin
			for (int j = 22; j < 25; j++) begin
				issueOp(opTable[j][7:4], opTable[j][3:0], 4'h0, width'($random(seed)), shiftAmt[a]);
			end
		end

		// random mix, mostly back to back
		for (int i = 0; i < numMix; i++) begin
			k = $unsigned($random(seed)) % 28;
			issueOp(opTable[k][7:4], opTable[k][3:0], 4'($random(seed)), width'($random(seed)),
				width'($random(seed)));
			if ($random(seed) % 4 == 0) begin
				idleCycle();
			end
		end
		idleCycle();
		idleCycle();
		@(posedge clk);
		if (expQ.size() != 0) begin
			errors++;
			$display("Error: %0d issued operations never showed resultValid", expQ.size());
		end
		errors += dut0.props0.failures;
		$display("Checks: %0d, errors: %0d, operations issued: %0d", checks, errors, issued);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: aluExec.f
hw/aluPkg.sv
hw/aluController.sv
hw/conditionCheck.sv
hw/alu.sv
hw/executeStage.sv
verification/executeStage_props.sv
verification/executeStage_tb.sv

// File: Makefile
# Verilator flow for the aluExec execute stage

VERILATOR ?= verilator
TOP       ?= executeStage_tb
FILELIST  ?= aluExec.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
